//--- design/expr_defs.svh
`ifndef EXPR_DEFS_SVH
`define EXPR_DEFS_SVH

// --------------------------------------------------------------------------
// widths
// --------------------------------------------------------------------------
`define EXPR_TOKEN_W      3    // number or opcode field
`define EXPR_VALUE_W      30   // signed stack entry
`define EXPR_OUT_W        64   // sign-extended result on out

// limits
`define EXPR_MAX_TOKENS   19   // longest frame
`define EXPR_STACK_DEPTH  10   // enough for 10 numbers in 19 tokens
`define EXPR_CNT_W        5    // token counter, holds 0..19 and one past
`define EXPR_TOP_W        4    // stack pointer, holds 0..10

// --------------------------------------------------------------------------
// operator codes carried in the token field
// --------------------------------------------------------------------------
`define EXPR_OP_ADD       3'd0 // a + b
`define EXPR_OP_SUB       3'd1 // a - b
`define EXPR_OP_MUL       3'd2 // a * b
`define EXPR_OP_ABS       3'd3 // |a + b|
`define EXPR_OP_DBL_SUB   3'd4 // 2 * (a - b)

`endif

//--- design/expr_pkg.sv
// types for the arithmetic side: stack values, tokens, opcodes
package expr_pkg;

	`include "expr_defs.svh"

	// one stack entry, wraps at 30 bits
	typedef logic signed [`EXPR_VALUE_W-1:0] value_t;

	// raw token field as it arrives on in
	typedef logic [`EXPR_TOKEN_W-1:0] token_t;

	// operator codes, 5..7 are unused and evaluate to 0
	typedef enum logic [`EXPR_TOKEN_W-1:0] {
		OP_ADD     = `EXPR_OP_ADD,
		OP_SUB     = `EXPR_OP_SUB,
		OP_MUL     = `EXPR_OP_MUL,
		OP_ABS     = `EXPR_OP_ABS,
		OP_DBL_SUB = `EXPR_OP_DBL_SUB,
		OP_RSV5    = 3'd5,
		OP_RSV6    = 3'd6,
		OP_RSV7    = 3'd7
	} opcode_e;

endpackage

//--- design/ctrl_pkg.sv
// types for the clk_2 frame sequencing
package ctrl_pkg;

	// frame fsm
	typedef enum logic [1:0] {
		ST_IDLE   = 2'd0, // waiting for first token, stack held clear
		ST_INPUT  = 2'd1, // collecting tokens
		ST_CAL    = 2'd2, // prefix replay, last token first
		ST_OUTPUT = 2'd3  // one cycle, result handed to clk_3
	} state_e;

	// sampled from mode with the first token of a frame
	typedef enum logic {
		NOT_PREFIX  = 1'b0,
		NOT_POSTFIX = 1'b1
	} notation_e;

endpackage

//--- design/token_launch.sv
`timescale 1ns/1ns
`include "expr_defs.svh"

// clk_1 side of the token crossing
// fields are held until the next in_valid, the toggle tells clk_2 a new one is there
module token_launch (
	input  logic             clk_1,
	input  logic             rst_n,
	input  logic             in_valid,
	input  expr_pkg::token_t in,
	input  logic             operator,
	input  logic             mode,
	input  logic             in_last,
	output expr_pkg::token_t tok_value,
	output logic             tok_is_op,
	output logic             tok_mode,
	output logic             tok_last,
	output logic             tok_toggle
);

	// holding register, payload only
	always_ff @(posedge clk_1) begin
		if (in_valid) begin
			tok_value <= in;
			tok_is_op <= operator;  // 1 = opcode in tok_value
			tok_mode  <= mode;      // only meaningful on first token
			tok_last  <= in_last;
		end
	end

	// launch flop, flips once per token
	always_ff @(posedge clk_1) begin
		if (!rst_n) begin
			tok_toggle <= 1'b0;
		end else if (in_valid) begin
			tok_toggle <= ~tok_toggle;
		end
	end

	// clk_2 needs the fields stable through its sync delay
	a_token_spacing: assert property (@(posedge clk_1) disable iff (!rst_n)
		in_valid |=> !in_valid [*3]);

endmodule

//--- design/toggle_sync.sv
`timescale 1ns/1ns

// toggle in from another clock domain, one-cycle pulse out per flip
// two sync flops plus a history flop
module toggle_sync (
	input  logic clk,
	input  logic rst_n,
	input  logic toggle_in,
	output logic pulse
);

	logic sync_q1; // may go metastable
	logic sync_q2; // settled copy
	logic hist_q;  // sync_q2 one cycle back

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sync_q1 <= 1'b0;
			sync_q2 <= 1'b0;
			hist_q  <= 1'b0;
		end else begin
			sync_q1 <= toggle_in;
			sync_q2 <= sync_q1;
			hist_q  <= sync_q2;
		end
	end

	// edge of either polarity on the settled copy
	assign pulse = sync_q2 ^ hist_q;

	// sender flips no faster than once per two receive cycles
	a_pulse_single: assert property (@(posedge clk) disable iff (!rst_n)
		pulse |=> !pulse);

endmodule

//--- design/expr_alu.sv
`timescale 1ns/1ns

// five operations, everything wraps to the 30-bit value width
module expr_alu (
	input  expr_pkg::value_t  a,   // operand nearer the front of the expression
	input  expr_pkg::value_t  b,
	input  expr_pkg::opcode_e op,
	output expr_pkg::value_t  y
);

	expr_pkg::value_t sum;
	expr_pkg::value_t diff;
	expr_pkg::value_t prod;
	expr_pkg::value_t sum_abs;
	expr_pkg::value_t diff_x2;

	assign sum  = a + b;
	assign diff = a - b;
	assign prod = a * b;   // low 30 bits kept

	// magnitude of the wrapped sum, most negative value stays as is
	assign sum_abs = sum[$bits(sum)-1] ? -sum : sum;

	// double by shift, top bit falls off
	assign diff_x2 = diff <<< 1;

	always_comb begin
		case (op)
			expr_pkg::OP_ADD:     y = sum;
			expr_pkg::OP_SUB:     y = diff;
			expr_pkg::OP_MUL:     y = prod;
			expr_pkg::OP_ABS:     y = sum_abs;
			expr_pkg::OP_DBL_SUB: y = diff_x2;
			default:              y = '0;   // codes 5..7
		endcase
	end

endmodule

//--- design/eval_stack.sv
`timescale 1ns/1ns
`include "expr_defs.svh"

// operand stack, entry 0 at the bottom
// combine pops two, alu result lands where the lower one was
module eval_stack (
	input  logic                   clk_2,
	input  logic                   rst_n,
	input  logic                   push,
	input  logic                   combine,
	input  expr_pkg::value_t       push_value,
	input  expr_pkg::opcode_e      op,
	input  logic                   swap_order,  // a = entry below top
	input  logic                   clear,
	output expr_pkg::value_t       top_value,
	output logic [`EXPR_TOP_W-1:0] depth
);

	expr_pkg::value_t       stack_q [`EXPR_STACK_DEPTH];
	logic [`EXPR_TOP_W-1:0] top_q;   // live entries, also next free slot
	logic [`EXPR_TOP_W-1:0] hi_idx;  // top entry
	logic [`EXPR_TOP_W-1:0] lo_idx;  // one below
	expr_pkg::value_t       hi_val;
	expr_pkg::value_t       lo_val;
	expr_pkg::value_t       opnd_a;
	expr_pkg::value_t       opnd_b;
	expr_pkg::value_t       alu_y;

	assign hi_idx = top_q - 1'b1;
	assign lo_idx = top_q - 2'd2;

	// zero when the stack is too shallow, avoids reading past the array
	assign hi_val = (top_q >= 2) ? stack_q[hi_idx] : '0;
	assign lo_val = (top_q >= 2) ? stack_q[lo_idx] : '0;

	assign opnd_a = swap_order ? lo_val : hi_val;
	assign opnd_b = swap_order ? hi_val : lo_val;

	expr_alu u_alu (
		.a  (opnd_a),
		.b  (opnd_b),
		.op (op),
		.y  (alu_y)
	);

	// --------------------------------------------------------------------------
	// pointer and storage
	// --------------------------------------------------------------------------
	always_ff @(posedge clk_2) begin
		if (!rst_n) begin
			top_q <= '0;
		end else if (clear) begin
			top_q <= '0;
		end else if (push) begin
			top_q <= top_q + 1'b1;
		end else if (combine) begin
			top_q <= top_q - 1'b1; // two out, one in
		end
	end

	always_ff @(posedge clk_2) begin
		if (push) stack_q[top_q] <= push_value;
		else if (combine) stack_q[lo_idx] <= alu_y;
	end

	assign top_value = stack_q[0]; // whole expression ends up here
	assign depth     = top_q;

	// expr_ctrl checks depth before it asks
	a_combine_depth: assert property (@(posedge clk_2) disable iff (!rst_n)
		combine |-> top_q >= 2);
	a_push_room: assert property (@(posedge clk_2) disable iff (!rst_n)
		push |-> top_q < `EXPR_STACK_DEPTH);

endmodule

//--- design/expr_ctrl.sv
`timescale 1ns/1ns
`include "expr_defs.svh"

// clk_2 frame control: token buffer, fsm, stack sequencing, result launch
module expr_ctrl (
	input  logic                   clk_2,
	input  logic                   rst_n,
	input  logic                   tok_toggle,  // from token_launch, clk_1
	input  expr_pkg::token_t       tok_value,
	input  logic                   tok_is_op,
	input  logic                   tok_mode,
	input  logic                   tok_last,
	input  expr_pkg::value_t       top_value,   // stack entry 0
	input  logic [`EXPR_TOP_W-1:0] depth,
	output logic                   stack_push,
	output logic                   stack_combine,
	output expr_pkg::value_t       stack_value,
	output expr_pkg::opcode_e      stack_op,
	output logic                   swap_order,
	output logic                   stack_clear,
	output expr_pkg::value_t       result,
	output logic                   res_toggle
);

	ctrl_pkg::state_e       state_q;
	ctrl_pkg::state_e       state_d;
	ctrl_pkg::notation_e    notation_q;
	ctrl_pkg::notation_e    notation;                   // valid already on first token
	logic                   tok_strobe;
	logic                   accept;                     // token taken this cycle
	logic                   step;                       // one stack operation this cycle
	logic [`EXPR_CNT_W-1:0] cnt_q;                      // tokens stored, counts down in cal
	logic [`EXPR_CNT_W-1:0] rd_idx;
	expr_pkg::token_t       tok_buf [`EXPR_MAX_TOKENS];
	logic                   op_buf  [`EXPR_MAX_TOKENS];
	expr_pkg::token_t       cur_tok;
	logic                   cur_is_op;

	toggle_sync u_tok_sync (
		.clk       (clk_2),
		.rst_n     (rst_n),
		.toggle_in (tok_toggle),
		.pulse     (tok_strobe)
	);

	assign accept   = tok_strobe && (state_q == ctrl_pkg::ST_IDLE || state_q == ctrl_pkg::ST_INPUT);
	assign notation = (state_q == ctrl_pkg::ST_IDLE) ? ctrl_pkg::notation_e'(tok_mode) : notation_q;
	assign rd_idx   = cnt_q - 1'b1; // replay walks back from the last token

	// --------------------------------------------------------------------------
	// stack commands
	// --------------------------------------------------------------------------
	assign cur_tok   = (state_q == ctrl_pkg::ST_CAL) ? tok_buf[rd_idx] : tok_value;
	assign cur_is_op = (state_q == ctrl_pkg::ST_CAL) ? op_buf[rd_idx] : tok_is_op;
	assign step      = (state_q == ctrl_pkg::ST_CAL) || (accept && notation == ctrl_pkg::NOT_POSTFIX);

	// malformed frames just skip the illegal step
	assign stack_push    = step && !cur_is_op && (depth < `EXPR_STACK_DEPTH);
	assign stack_combine = step && cur_is_op && (depth >= 2);
	assign stack_value   = {{(`EXPR_VALUE_W-`EXPR_TOKEN_W){1'b0}}, cur_tok}; // numbers 0..7
	assign stack_op      = expr_pkg::opcode_e'(cur_tok);
	assign swap_order    = (notation == ctrl_pkg::NOT_POSTFIX); // a sits below top in postfix
	assign stack_clear   = (state_q == ctrl_pkg::ST_IDLE) && !tok_strobe;

	// --------------------------------------------------------------------------
	// frame fsm
	// --------------------------------------------------------------------------
	always_comb begin
		state_d = state_q;
		case (state_q)
			ctrl_pkg::ST_IDLE, ctrl_pkg::ST_INPUT: begin
				if (tok_strobe) begin
					if (!tok_last) state_d = ctrl_pkg::ST_INPUT;
					else if (notation == ctrl_pkg::NOT_POSTFIX) state_d = ctrl_pkg::ST_OUTPUT;
					else state_d = ctrl_pkg::ST_CAL;
				end
			end
			ctrl_pkg::ST_CAL:    if (cnt_q <= 1) state_d = ctrl_pkg::ST_OUTPUT; // last replay step
			ctrl_pkg::ST_OUTPUT: state_d = ctrl_pkg::ST_IDLE;
			default:             state_d = ctrl_pkg::ST_IDLE;
		endcase
	end

	always_ff @(posedge clk_2) begin
		if (!rst_n) begin
			state_q    <= ctrl_pkg::ST_IDLE;
			notation_q <= ctrl_pkg::NOT_PREFIX;
			cnt_q      <= '0;
			res_toggle <= 1'b0;
		end else begin
			state_q <= state_d;
			if (state_q == ctrl_pkg::ST_IDLE && tok_strobe) notation_q <= notation;
			if (accept) cnt_q <= cnt_q + 1'b1;
			else if (state_q == ctrl_pkg::ST_CAL) cnt_q <= cnt_q - 1'b1;
			else if (state_q == ctrl_pkg::ST_OUTPUT) cnt_q <= '0;
			if (state_q == ctrl_pkg::ST_OUTPUT) res_toggle <= ~res_toggle; // tell clk_3
		end
	end

	// token buffer, written in arrival order
	always_ff @(posedge clk_2) begin
		if (accept && cnt_q < `EXPR_MAX_TOKENS) begin
			tok_buf[cnt_q] <= tok_value;
			op_buf[cnt_q]  <= tok_is_op;
		end
	end

	// final value, held while clk_3 picks it up
	always_ff @(posedge clk_2) begin
		if (state_q == ctrl_pkg::ST_OUTPUT) result <= top_value;
	end

	a_cnt_limit: assert property (@(posedge clk_2) disable iff (!rst_n)
		cnt_q <= `EXPR_MAX_TOKENS);

endmodule

//--- design/result_port.sv
`timescale 1ns/1ns
`include "expr_defs.svh"

// clk_3 side of the result crossing
module result_port (
	input  logic                   clk_3,
	input  logic                   rst_n,
	input  expr_pkg::value_t       result,     // held stable by expr_ctrl
	input  logic                   res_toggle,
	output logic                   out_valid,
	output logic [`EXPR_OUT_W-1:0] out
);

	logic                   res_pulse;
	logic [`EXPR_OUT_W-1:0] out_q;

	toggle_sync u_res_sync (
		.clk       (clk_3),
		.rst_n     (rst_n),
		.toggle_in (res_toggle),
		.pulse     (res_pulse)
	);

	// one cycle per result
	always_ff @(posedge clk_3) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= res_pulse;
		end
	end

	// sign-extend 30 to 64
	always_ff @(posedge clk_3) begin
		if (res_pulse) begin
			out_q <= {{(`EXPR_OUT_W-`EXPR_VALUE_W){result[`EXPR_VALUE_W-1]}}, result};
		end
	end

	assign out = out_valid ? out_q : '0; // quiet between results

endmodule

//--- design/expr_top.sv
`timescale 1ns/1ns
`include "expr_defs.svh"

// three clock domains: token entry, evaluation, result
module expr_top (
	input  logic                   clk_1,
	input  logic                   clk_2,
	input  logic                   clk_3,
	input  logic                   rst_n,
	input  logic                   in_valid,
	input  expr_pkg::token_t       in,
	input  logic                   operator,
	input  logic                   mode,
	input  logic                   in_last,
	output logic                   out_valid,
	output logic [`EXPR_OUT_W-1:0] out
);

	// clk_1 to clk_2
	expr_pkg::token_t       tok_value;
	logic                   tok_is_op;
	logic                   tok_mode;
	logic                   tok_last;
	logic                   tok_toggle;

	// inside clk_2
	logic                   stack_push;
	logic                   stack_combine;
	expr_pkg::value_t       stack_value;
	expr_pkg::opcode_e      stack_op;
	logic                   swap_order;
	logic                   stack_clear;
	expr_pkg::value_t       top_value;
	logic [`EXPR_TOP_W-1:0] depth;

	// clk_2 to clk_3
	expr_pkg::value_t       result;
	logic                   res_toggle;

	token_launch u_launch (
		.clk_1      (clk_1),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.in         (in),
		.operator   (operator),
		.mode       (mode),
		.in_last    (in_last),
		.tok_value  (tok_value),
		.tok_is_op  (tok_is_op),
		.tok_mode   (tok_mode),
		.tok_last   (tok_last),
		.tok_toggle (tok_toggle)
	);

	expr_ctrl u_ctrl (
		.clk_2         (clk_2),
		.rst_n         (rst_n),
		.tok_toggle    (tok_toggle),
		.tok_value     (tok_value),
		.tok_is_op     (tok_is_op),
		.tok_mode      (tok_mode),
		.tok_last      (tok_last),
		.top_value     (top_value),
		.depth         (depth),
		.stack_push    (stack_push),
		.stack_combine (stack_combine),
		.stack_value   (stack_value),
		.stack_op      (stack_op),
		.swap_order    (swap_order),
		.stack_clear   (stack_clear),
		.result        (result),
		.res_toggle    (res_toggle)
	);

	eval_stack u_stack (
		.clk_2      (clk_2),
		.rst_n      (rst_n),
		.push       (stack_push),
		.combine    (stack_combine),
		.push_value (stack_value),
		.op         (stack_op),
		.swap_order (swap_order),
		.clear      (stack_clear),
		.top_value  (top_value),
		.depth      (depth)
	);

	result_port u_result (
		.clk_3      (clk_3),
		.rst_n      (rst_n),
		.result     (result),
		.res_toggle (res_toggle),
		.out_valid  (out_valid),
		.out        (out)
	);

endmodule

//--- test/expr_tb.sv
`timescale 1ns/1ns
`include "expr_defs.svh"

// expression evaluator testbench, three clocks, table of frames
module expr_tb;

	localparam int MAX_FRAMES = 16;

	logic                   clk_1;
	logic                   clk_2;
	logic                   clk_3;
	logic                   rst_n;
	logic                   in_valid;
	logic [2:0]             in;
	logic                   operator;
	logic                   mode;
	logic                   in_last;
	logic                   out_valid;
	logic [`EXPR_OUT_W-1:0] out;

	// frame table, token = {operator bit, 3-bit field}
	logic                   frame_mode [MAX_FRAMES];
	int                     frame_len  [MAX_FRAMES];
	logic [3:0]             frame_tok  [MAX_FRAMES][`EXPR_MAX_TOKENS];
	logic [`EXPR_OUT_W-1:0] frame_exp  [MAX_FRAMES];
	int                     num_frames = 0;

	int                     err_value    = 0; // wrong results
	int                     err_protocol = 0; // stray out, pulse width or count
	int                     pulse_cnt    = 0;
	logic                   prev_valid   = 1'b0;
	logic [`EXPR_OUT_W-1:0] last_out     = '0;
	int unsigned            cycle_cnt    = 0;
	int unsigned            cycle_limit  = 0; // 0 until the table is known
	int                     f;

	expr_top dut_i (
		.clk_1     (clk_1),
		.clk_2     (clk_2),
		.clk_3     (clk_3),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in        (in),
		.operator  (operator),
		.mode      (mode),
		.in_last   (in_last),
		.out_valid (out_valid),
		.out       (out)
	);

	// --------------------------------------------------------------------------
	// clocks 10 / 6 / 8 ns
	// --------------------------------------------------------------------------
	initial begin
		clk_1 = 1'b0;
		forever #5 clk_1 = ~clk_1;
	end

	initial begin
		clk_2 = 1'b0;
		forever #3 clk_2 = ~clk_2;
	end

	initial begin
		clk_3 = 1'b0;
		forever #4 clk_3 = ~clk_3;
	end

	// run limit in clk_1 cycles
	always @(posedge clk_1) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
			$display("timed out after %0d clk_1 cycles, result never arrived", cycle_cnt);
			$display("Checks failed");
			$finish;
		end
	end

	// out watcher, sampled mid-cycle of clk_3
	always @(negedge clk_3) begin
		if (rst_n === 1'b1) begin
			if (out_valid === 1'b1) begin
				if (prev_valid) begin
					$display("out_valid stayed high for more than one clk_3 cycle");
					err_protocol++;
				end
				last_out = out;
				pulse_cnt++;
			end else if (out !== 64'd0) begin
				$display("ERR out while out_valid low: got %h expected %h", out, 64'd0);
				err_protocol++;
			end
			prev_valid = (out_valid === 1'b1);
		end
	end

	// --------------------------------------------------------------------------
	// table building
	// --------------------------------------------------------------------------
	task begin_frame(input logic m);
		frame_mode[num_frames] = m;
		frame_len[num_frames]  = 0;
	endtask

	task add_num(input logic [2:0] v);
		frame_tok[num_frames][frame_len[num_frames]] = {1'b0, v};
		frame_len[num_frames]++;
	endtask

	task add_op(input logic [2:0] code);
		frame_tok[num_frames][frame_len[num_frames]] = {1'b1, code};
		frame_len[num_frames]++;
	endtask

	task end_frame(input logic [`EXPR_OUT_W-1:0] expected);
		frame_exp[num_frames] = expected;
		num_frames++;
	endtask

	// one token per 4 clk_1 cycles, in_last on the final one
	task send_frame(input int idx);
		int i;
		for (i = 0; i < frame_len[idx]; i++) begin
			@(negedge clk_1);
			in_valid = 1'b1;
			in       = frame_tok[idx][i][2:0];
			operator = frame_tok[idx][i][3];
			mode     = frame_mode[idx];
			in_last  = (i == frame_len[idx] - 1);
			@(negedge clk_1);
			in_valid = 1'b0;
			in_last  = 1'b0;
			repeat (2) @(negedge clk_1);
		end
	endtask

	task check_result(input int idx);
		while (pulse_cnt < idx + 1) @(negedge clk_1);
		if (last_out !== frame_exp[idx]) begin
			$display("ERR frame %0d out: got %h expected %h", idx, last_out, frame_exp[idx]);
			err_value++;
		end
	endtask

	initial begin
		rst_n    = 1'b0;
		in_valid = 1'b0;
		in       = 3'd0;
		operator = 1'b0;
		mode     = 1'b0;
		in_last  = 1'b0;

		// postfix, one per operator
		begin_frame(ctrl_pkg::NOT_POSTFIX);
		add_num(3); add_num(5); add_op(`EXPR_OP_ADD); end_frame(64'd8);
		begin_frame(ctrl_pkg::NOT_POSTFIX);
		add_num(2); add_num(7); add_op(`EXPR_OP_SUB); end_frame(-64'sd5);
		begin_frame(ctrl_pkg::NOT_POSTFIX);
		add_num(6); add_num(7); add_op(`EXPR_OP_MUL); end_frame(64'd42);
		begin_frame(ctrl_pkg::NOT_POSTFIX);
		add_num(1); add_num(6); add_op(`EXPR_OP_ABS); end_frame(64'd7);
		begin_frame(ctrl_pkg::NOT_POSTFIX);
		add_num(2); add_num(5); add_op(`EXPR_OP_DBL_SUB); end_frame(-64'sd6);

		// prefix, operand order and nesting
		begin_frame(ctrl_pkg::NOT_PREFIX);
		add_op(`EXPR_OP_SUB); add_num(7); add_num(2); end_frame(64'd5);
		begin_frame(ctrl_pkg::NOT_PREFIX); // (1+2)*(7-3)
		add_op(`EXPR_OP_MUL); add_op(`EXPR_OP_ADD); add_num(1); add_num(2);
		add_op(`EXPR_OP_SUB); add_num(7); add_num(3); end_frame(64'd12);
		begin_frame(ctrl_pkg::NOT_PREFIX); // |(0-5)+3|
		add_op(`EXPR_OP_ABS); add_op(`EXPR_OP_SUB); add_num(0); add_num(5); add_num(3);
		end_frame(64'd2);

		// 19 tokens, ten 7s multiplied, 7^10 = 0x10d63af1
		begin_frame(ctrl_pkg::NOT_POSTFIX);
		add_num(7);
		for (f = 0; f < 9; f++) begin
			add_num(7);
			add_op(`EXPR_OP_MUL);
		end
		end_frame(64'h0000_0000_10d6_3af1);

		// 19 tokens prefix, (0-7)*7^8, ten entries deep on replay
		begin_frame(ctrl_pkg::NOT_PREFIX);
		for (f = 0; f < 8; f++) add_op(`EXPR_OP_MUL);
		add_op(`EXPR_OP_SUB); add_num(0); add_num(7);
		for (f = 0; f < 8; f++) add_num(7);
		end_frame(64'hffff_ffff_fd98_40b9); // -7^9

		// unused codes, then alternating notation back to back
		begin_frame(ctrl_pkg::NOT_POSTFIX); // 0 + 3
		add_num(4); add_num(5); add_op(3'd5); add_num(3); add_op(`EXPR_OP_ADD);
		end_frame(64'd3);
		begin_frame(ctrl_pkg::NOT_PREFIX); // 6 + 0
		add_op(`EXPR_OP_ADD); add_num(6); add_op(3'd7); add_num(2); add_num(1);
		end_frame(64'd6);
		begin_frame(ctrl_pkg::NOT_POSTFIX); // 2*((7-1)-2)
		add_num(7); add_num(1); add_op(`EXPR_OP_SUB); add_num(2); add_op(`EXPR_OP_DBL_SUB);
		end_frame(64'd8);
		begin_frame(ctrl_pkg::NOT_PREFIX); // 1 - 3*4
		add_op(`EXPR_OP_SUB); add_num(1); add_op(`EXPR_OP_MUL); add_num(3); add_num(4);
		end_frame(-64'sd11);
		begin_frame(ctrl_pkg::NOT_POSTFIX); // |3 + (0-6)|
		add_num(3); add_num(0); add_num(6); add_op(`EXPR_OP_SUB); add_op(`EXPR_OP_ABS);
		end_frame(64'd3);

		// budget per frame, doubled
		for (f = 0; f < num_frames; f++) cycle_limit += 4 * frame_len[f] + 40;
		cycle_limit = 2 * cycle_limit;

		repeat (3) @(posedge clk_1);
		@(negedge clk_1);
		rst_n = 1'b1;

		@(negedge clk_3);
		if (out_valid !== 1'b0) begin
			$display("ERR out_valid after reset: got %h expected %h", out_valid, 1'b0);
			err_protocol++;
		end

		for (f = 0; f < num_frames; f++) begin
			send_frame(f);
			check_result(f);
			repeat (10) @(negedge clk_1);
			if (pulse_cnt != f + 1) begin
				$display("frame %0d gave extra out_valid pulses, %0d seen after %0d frames",
					f, pulse_cnt, f + 1);
				err_protocol++;
			end
		end

		$display("errors: %0d wrong results, %0d protocol", err_value, err_protocol);
		if (err_value + err_protocol == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

//--- sim.f
+incdir+design
design/expr_pkg.sv
design/ctrl_pkg.sv
design/token_launch.sv
design/toggle_sync.sv
design/expr_alu.sv
design/eval_stack.sv
design/expr_ctrl.sv
design/result_port.sv
design/expr_top.sv
test/expr_tb.sv
